/* files.f */
logic/pcs_pkg.sv
logic/gpio_register_file.sv
logic/block_encoder.sv
logic/block_scrambler.sv
logic/block_decoder.sv
logic/capture_ram.sv
logic/pcs_loopback_top.sv
test/pcs_loopback_sva.sv
test/pcs_loopback_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = pcs_loopback_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(wildcard logic/*.sv test/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* test/pcs_loopback_tb.sv */
module pcs_loopback_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import pcs_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int N_MAIN_BLOCKS = 16;
    localparam int N_SCR_BLOCKS  = 8;
    localparam int N_DROP_BLOCKS = 4;
    localparam int WORD_CYCLES   = 10; // one block sent and read back
    localparam int TEST_CYCLES   = (N_MAIN_BLOCKS + N_SCR_BLOCKS + 2 * N_DROP_BLOCKS)
                                   * WORD_CYCLES + 200;
    localparam int POLL_LIMIT    = 20;
    localparam int FLUSH_CYCLES  = 8;
    localparam int CHECK_W       = CTRL_W + DATA_W;

    logic                  i_clock;
    logic                  i_reset;
    logic [GPIO_W-1:0]     i_gpio_in;
    logic [DATA_W-1:0]     i_tx_data;
    logic [CTRL_W-1:0]     i_tx_ctrl;
    logic                  i_tx_valid;
    logic [GPIO_W-1:0]     o_gpio_out;
    logic                  o_invalid_opcode;

    logic [31:0]           lcg_state;
    logic [SCR_TAP_B-1:0]  scr_line;  // index d-1 holds the bit d positions back
    logic [SCR_TAP_B-1:0]  dsc_line;
    logic [CHECK_W-1:0]    expected_words [$];
    logic [CHECK_W-1:0]    exp_q [$];
    logic [CHECK_W-1:0]    got_q [$];
    string                 name_q [$];
    int                    pushed_count = 0;
    int                    checked_count = 0;
    int                    error_count = 0;
    int                    tests_run = 0;
    int                    tests_failed = 0;

    pcs_loopback_top pcs_loopback_top_inst (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_gpio_in        (i_gpio_in),
        .i_tx_data        (i_tx_data),
        .i_tx_ctrl        (i_tx_ctrl),
        .i_tx_valid       (i_tx_valid),
        .o_gpio_out       (o_gpio_out),
        .o_invalid_opcode (o_invalid_opcode)
    );

    initial
    begin
        i_clock = 1'b0;
        forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // self-synchronous x^58 + x^39 + 1 over the payload, bit 0 first
    function automatic logic [DATA_W-1:0] run_scrambler(input logic [DATA_W-1:0] payload,
                                                        input logic descramble);
        logic [SCR_TAP_B-1:0] line;
        logic [DATA_W-1:0]    result;
        line = descramble ? dsc_line : scr_line;
        for (int i = 0; i < DATA_W; i++)
        begin
            result[i] = payload[i] ^ line[SCR_TAP_A-1] ^ line[SCR_TAP_B-1];
            line = {line[SCR_TAP_B-2:0], descramble ? payload[i] : result[i]};
        end
        if (descramble)
            dsc_line = line;
        else
            scr_line = line;
        return result;
    endfunction

    // expected capture word {mask, data}
    function automatic logic [CHECK_W-1:0] predict_word(input logic [DATA_W-1:0] data,
                                                        input logic [CTRL_W-1:0] ctrl,
                                                        input logic scr_on, input logic dsc_on);
        logic [HDR_W-1:0]  header;
        logic [DATA_W-1:0] payload;
        header  = (ctrl == '0) ? HDR_DATA : HDR_CTRL;
        payload = (ctrl == '0) ? data : {data[DATA_W-1:CTRL_W], ctrl};
        if (scr_on)
            payload = run_scrambler(payload, 1'b0);
        if (dsc_on)
            payload = run_scrambler(payload, 1'b1);
        if (header == HDR_DATA)
            return {{CTRL_W{1'b0}}, payload};
        return {payload[CTRL_W-1:0], payload[DATA_W-1:CTRL_W], {CTRL_W{1'b0}}};
    endfunction

    function automatic logic [GPIO_W-1:0] status_value(input logic [N_STAGES-1:0] enables,
                                                       input logic rd_en);
        return {23'b0, rd_en, 3'b0, enables}; // read enable at bit 8
    endfunction

    task automatic push_check(input string name, input logic [CHECK_W-1:0] got,
                              input logic [CHECK_W-1:0] exp);
        name_q.push_back(name);
        exp_q.push_back(exp);
        got_q.push_back(got);
        pushed_count++;
    endtask

    task automatic reset_dut();
        i_reset = 1'b1;
        repeat (2) @(posedge i_clock);
        @(negedge i_clock);
        i_reset = 1'b0;
        scr_line = '0;
        dsc_line = '0;
    endtask

    // the leading falling edge also gives the idle cycle after an address write
    task automatic send_command(input logic [OPCODE_W-1:0] op, input logic [ARG_W-1:0] arg);
        @(negedge i_clock);
        i_gpio_in = {1'b1, op, arg};
        @(negedge i_clock);
        i_gpio_in = '0;
    endtask

    task automatic read_gpio(input logic [OPCODE_W-1:0] op, output logic [GPIO_W-1:0] value);
        send_command(op, '0);
        value = o_gpio_out;
    endtask

    task automatic run_burst(input int count, input logic scr_on, input logic dsc_on);
        logic [DATA_W-1:0] data;
        logic [CTRL_W-1:0] ctrl;
        logic [31:0]       r;
        expected_words.delete();
        for (int i = 0; i < count; i++)
        begin
            data = {next_random(), next_random()};
            r    = next_random();
            ctrl = (i % 2 == 1) ? r[CTRL_W-1:0] : '0; // odd blocks are control
            if (i % 2 == 1 && ctrl == '0)
                ctrl = 8'h01;
            expected_words.push_back(predict_word(data, ctrl, scr_on, dsc_on));
            @(negedge i_clock);
            i_tx_data  = data;
            i_tx_ctrl  = ctrl;
            i_tx_valid = 1'b1;
        end
        @(negedge i_clock);
        i_tx_valid = 1'b0;
    endtask

    task automatic wait_write_pointer(input int target);
        logic [GPIO_W-1:0] value;
        int                polls;
        polls = 0;
        read_gpio(OP_READ_WPTR, value);
        while (value != GPIO_W'(target) && polls < POLL_LIMIT)
        begin
            read_gpio(OP_READ_WPTR, value);
            polls++;
        end
        if (value != GPIO_W'(target))
            $display("write pointer did not reach %0d within %0d polls", target, POLL_LIMIT);
        push_check("o_gpio_out (write pointer)", CHECK_W'(value), CHECK_W'(target));
    endtask

    task automatic check_ram(input int count);
        logic [GPIO_W-1:0] lo;
        logic [GPIO_W-1:0] hi;
        logic [GPIO_W-1:0] mask;
        for (int i = 0; i < count; i++)
        begin
            send_command(OP_READ_ADDR, ARG_W'(i));
            read_gpio(OP_READ_DATA_LOW, lo);
            read_gpio(OP_READ_DATA_HIGH, hi);
            read_gpio(OP_READ_CTRL, mask);
            push_check($sformatf("o_gpio_out (ram word %0d)", i),
                       {mask[CTRL_W-1:0], hi, lo}, expected_words[i]);
            push_check($sformatf("o_gpio_out (ram mask %0d upper bits)", i),
                       CHECK_W'(mask[GPIO_W-1:CTRL_W]), '0);
        end
    endtask

    task automatic finish_test(input int number, input string label, input int errors_before);
        wait (checked_count == pushed_count);
        tests_run++;
        if (error_count == errors_before)
            $display("test %0d %s: ok", number, label);
        else
        begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", number, label,
                     error_count - errors_before);
        end
    endtask

    initial
    begin : compare_proc
        logic [CHECK_W-1:0] got;
        logic [CHECK_W-1:0] exp;
        string              name;
        forever
        begin
            wait (pushed_count > checked_count);
            got  = got_q.pop_front();
            exp  = exp_q.pop_front();
            name = name_q.pop_front();
            if (got !== exp)
            begin
                $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
                error_count++;
            end
            checked_count++;
        end
    end

    initial
    begin : watchdog_proc
        #(TEST_CYCLES * CLK_PERIOD * 2);
        $display("watchdog expired, run did not finish within %0d cycles", 2 * TEST_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin : main_proc
        logic [GPIO_W-1:0] value;
        logic [GPIO_W-1:0] baseline;
        int                errors_before;
        i_reset    = 1'b1;
        i_gpio_in  = '0;
        i_tx_data  = '0;
        i_tx_ctrl  = '0;
        i_tx_valid = 1'b0;
        lcg_state  = 32'd45487;
        reset_dut();

        errors_before = error_count;
        read_gpio(OP_READ_STATUS, value);
        push_check("o_gpio_out (status)", CHECK_W'(value), '0);
        read_gpio(OP_READ_WPTR, value);
        push_check("o_gpio_out (write pointer)", CHECK_W'(value), '0);
        push_check("o_invalid_opcode", CHECK_W'(o_invalid_opcode), '0);
        finish_test(1, "reset values", errors_before);

        errors_before = error_count;
        send_command(OP_ENABLE, ARG_W'(5'b11111));
        send_command(OP_READ_MEM_ENB, ARG_W'(1));
        run_burst(N_MAIN_BLOCKS, 1'b1, 1'b1);
        wait_write_pointer(N_MAIN_BLOCKS);
        check_ram(N_MAIN_BLOCKS);
        finish_test(2, "full loopback", errors_before);

        errors_before = error_count;
        reset_dut(); // scrambler history starts from zero
        send_command(OP_ENABLE, ARG_W'(5'b11011));
        send_command(OP_READ_MEM_ENB, ARG_W'(1));
        run_burst(N_SCR_BLOCKS, 1'b1, 1'b0);
        wait_write_pointer(N_SCR_BLOCKS);
        check_ram(N_SCR_BLOCKS);
        finish_test(3, "scramble only", errors_before);

        errors_before = error_count;
        read_gpio(OP_READ_WPTR, baseline);
        send_command(OP_ENABLE, ARG_W'(5'b01111)); // ram stage off
        run_burst(N_DROP_BLOCKS, 1'b1, 1'b1);
        repeat (FLUSH_CYCLES) @(negedge i_clock);
        read_gpio(OP_READ_WPTR, value);
        push_check("o_gpio_out (write pointer, ram off)", CHECK_W'(value), CHECK_W'(baseline));
        send_command(OP_ENABLE, ARG_W'(5'b11110)); // encoder off
        run_burst(N_DROP_BLOCKS, 1'b0, 1'b0);
        repeat (FLUSH_CYCLES) @(negedge i_clock);
        read_gpio(OP_READ_WPTR, value);
        push_check("o_gpio_out (write pointer, encoder off)", CHECK_W'(value),
                   CHECK_W'(baseline));
        finish_test(4, "disabled stages", errors_before);

        errors_before = error_count;
        send_command(OP_ENABLE, ARG_W'(5'b10101));
        send_command(9'd9, '0);
        push_check("o_invalid_opcode", CHECK_W'(o_invalid_opcode), CHECK_W'(1));
        read_gpio(OP_READ_STATUS, value);
        push_check("o_gpio_out (status)", CHECK_W'(value),
                   CHECK_W'(status_value(5'b10101, 1'b1)));
        send_command(OP_READ_MEM_ENB, ARG_W'(1));
        read_gpio(OP_READ_WPTR, value);
        push_check("o_invalid_opcode", CHECK_W'(o_invalid_opcode), CHECK_W'(1));
        finish_test(5, "invalid opcode", errors_before);

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checked_count, error_count);
        if (error_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* test/pcs_loopback_sva.sv */
module pcs_loopback_sva
(
    input  logic                           i_clock,
    input  logic                           i_reset,
    input  logic [pcs_pkg::GPIO_W-1:0]     i_gpio_in,
    input  logic [pcs_pkg::GPIO_W-1:0]     i_gpio_out,
    input  logic [pcs_pkg::N_STAGES-1:0]   i_stage_enable,
    input  logic                           i_invalid_opcode
);
    timeunit 1ns;
    timeprecision 1ps;
    import pcs_pkg::*;

    logic strobe;

    assign strobe = i_gpio_in[GPIO_W-1];

    invalid_flag_sticky: assert property (@(posedge i_clock) disable iff (i_reset)
        $past(i_invalid_opcode) && !$past(i_reset) |-> i_invalid_opcode)
        else $error("invalid opcode flag fell outside reset");

    enables_clear_after_reset: assert property (@(posedge i_clock)
        $past(i_reset) |-> i_stage_enable == '0)
        else $error("stage enables not zero in the cycle after reset");

    // reset exit may clear the output without a strobe
    gpio_out_needs_strobe: assert property (@(posedge i_clock) disable iff (i_reset)
        !$stable(i_gpio_out) && !$past(i_reset) |-> $past(strobe))
        else $error("gpio output changed without a command strobe");

endmodule

bind gpio_register_file pcs_loopback_sva pcs_loopback_sva_inst (
    .i_clock          (i_clock),
    .i_reset          (i_reset),
    .i_gpio_in        (i_gpio_in),
    .i_gpio_out       (o_gpio_out),
    .i_stage_enable   (o_stage_enable),
    .i_invalid_opcode (o_invalid_opcode)
);

/* logic/pcs_loopback_top.sv */
module pcs_loopback_top
(
    input  logic                           i_clock,
    input  logic                           i_reset,
    input  logic [pcs_pkg::GPIO_W-1:0]     i_gpio_in,
    input  logic [pcs_pkg::DATA_W-1:0]     i_tx_data,
    input  logic [pcs_pkg::CTRL_W-1:0]     i_tx_ctrl,
    input  logic                           i_tx_valid,
    output logic [pcs_pkg::GPIO_W-1:0]     o_gpio_out,
    output logic                           o_invalid_opcode
);
    import pcs_pkg::*;

    logic [N_STAGES-1:0]     stage_enable;
    logic                    ram_rd_en;
    logic [RAM_ADDR_W-1:0]   ram_rd_addr;
    logic [DATA_W-1:0]       ram_rd_data;
    logic [CTRL_W-1:0]       ram_rd_ctrl;
    logic [RAM_ADDR_W-1:0]   ram_wptr;

    logic [BLOCK_W-1:0]      enc_block;
    logic                    enc_valid;
    logic [BLOCK_W-1:0]      scr_block;
    logic                    scr_valid;
    logic [BLOCK_W-1:0]      dsc_block;
    logic                    dsc_valid;
    logic [DATA_W-1:0]       dec_data;
    logic [CTRL_W-1:0]       dec_ctrl;
    logic                    dec_valid;

    gpio_register_file gpio_register_file_inst (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_gpio_in        (i_gpio_in),
        .i_ram_data       (ram_rd_data),
        .i_ram_ctrl       (ram_rd_ctrl),
        .i_ram_wptr       (ram_wptr),
        .o_gpio_out       (o_gpio_out),
        .o_stage_enable   (stage_enable),
        .o_read_enable    (ram_rd_en),
        .o_read_address   (ram_rd_addr),
        .o_invalid_opcode (o_invalid_opcode)
    );

    block_encoder block_encoder_inst (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_enable (stage_enable[ENB_ENCODER]),
        .i_valid  (i_tx_valid),
        .i_data   (i_tx_data),
        .i_ctrl   (i_tx_ctrl),
        .o_block  (enc_block),
        .o_valid  (enc_valid)
    );

    block_scrambler #(.DESCRAMBLE(1'b0)) block_scrambler_inst (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_enable (stage_enable[ENB_SCRAMBLER]),
        .i_valid  (enc_valid),
        .i_block  (enc_block),
        .o_block  (scr_block),
        .o_valid  (scr_valid)
    );

    block_scrambler #(.DESCRAMBLE(1'b1)) block_descrambler_inst (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_enable (stage_enable[ENB_DESCRAMBLER]),
        .i_valid  (scr_valid),
        .i_block  (scr_block),
        .o_block  (dsc_block),
        .o_valid  (dsc_valid)
    );

    block_decoder block_decoder_inst (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_enable (stage_enable[ENB_DECODER]),
        .i_valid  (dsc_valid),
        .i_block  (dsc_block),
        .o_data   (dec_data),
        .o_ctrl   (dec_ctrl),
        .o_valid  (dec_valid)
    );

    capture_ram capture_ram_inst (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_write_enable  (stage_enable[ENB_RAM]),
        .i_valid         (dec_valid),
        .i_data          (dec_data),
        .i_ctrl          (dec_ctrl),
        .i_read_enable   (ram_rd_en),
        .i_read_address  (ram_rd_addr),
        .o_read_data     (ram_rd_data),
        .o_read_ctrl     (ram_rd_ctrl),
        .o_write_pointer (ram_wptr)
    );

endmodule

/* logic/capture_ram.sv */
module capture_ram
(
    input  logic                               i_clock,
    input  logic                               i_reset,
    input  logic                               i_write_enable,
    input  logic                               i_valid,
    input  logic [pcs_pkg::DATA_W-1:0]         i_data,
    input  logic [pcs_pkg::CTRL_W-1:0]         i_ctrl,
    input  logic                               i_read_enable,
    input  logic [pcs_pkg::RAM_ADDR_W-1:0]     i_read_address,
    output logic [pcs_pkg::DATA_W-1:0]         o_read_data,
    output logic [pcs_pkg::CTRL_W-1:0]         o_read_ctrl,
    output logic [pcs_pkg::RAM_ADDR_W-1:0]     o_write_pointer
);
    import pcs_pkg::*;

    logic [CTRL_W+DATA_W-1:0]   mem [RAM_DEPTH];
    logic                       write_now;

    assign write_now = i_write_enable & i_valid;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_write_pointer <= '0;
        end
        else if (write_now)
        begin
            o_write_pointer <= o_write_pointer + 1'b1; // wraps at depth
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (write_now)
        begin
            mem[o_write_pointer] <= {i_ctrl, i_data};
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_read_enable)
        begin
            {o_read_ctrl, o_read_data} <= mem[i_read_address];
        end
    end

endmodule

/* logic/block_decoder.sv */
module block_decoder
(
    input  logic                           i_clock,
    input  logic                           i_reset,
    input  logic                           i_enable,
    input  logic                           i_valid,
    input  logic [pcs_pkg::BLOCK_W-1:0]    i_block,
    output logic [pcs_pkg::DATA_W-1:0]     o_data,
    output logic [pcs_pkg::CTRL_W-1:0]     o_ctrl,
    output logic                           o_valid
);
    import pcs_pkg::*;

    logic [HDR_W-1:0]    header;
    logic [DATA_W-1:0]   payload;

    assign header  = i_block[BLOCK_W-1:DATA_W];
    assign payload = i_block[DATA_W-1:0];

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid & i_enable;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (header == HDR_DATA)
        begin
            o_data <= payload;
            o_ctrl <= '0;
        end
        else
        begin
            // byte 0 carried the mask
            o_data <= {payload[DATA_W-1:CTRL_W], {CTRL_W{1'b0}}};
            o_ctrl <= payload[CTRL_W-1:0];
        end
    end

endmodule

/* logic/block_scrambler.sv */
module block_scrambler
#(
    parameter bit DESCRAMBLE = 1'b0
)
(
    input  logic                           i_clock,
    input  logic                           i_reset,
    input  logic                           i_enable,
    input  logic                           i_valid,
    input  logic [pcs_pkg::BLOCK_W-1:0]    i_block,
    output logic [pcs_pkg::BLOCK_W-1:0]    o_block,
    output logic                           o_valid
);
    import pcs_pkg::*;

    logic [SCR_TAP_B-1:0]   history;
    logic [SCR_TAP_B-1:0]   history_next;
    logic [DATA_W-1:0]      payload_next;

    // bit 0 first, history[0] holds the newest bit
    always_comb
    begin
        history_next = history;
        for (int i = 0; i < DATA_W; i++)
        begin
            payload_next[i] = i_block[i] ^ history_next[SCR_TAP_A-1]
                              ^ history_next[SCR_TAP_B-1];
            if (DESCRAMBLE)
            begin
                history_next = {history_next[SCR_TAP_B-2:0], i_block[i]};
            end
            else
            begin
                history_next = {history_next[SCR_TAP_B-2:0], payload_next[i]};
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            history <= '0;
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid; // bypass keeps the valid
            if (i_enable && i_valid)
            begin
                history <= history_next;
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_enable)
        begin
            o_block <= {i_block[BLOCK_W-1:DATA_W], payload_next}; // header untouched
        end
        else
        begin
            o_block <= i_block;
        end
    end

endmodule

/* logic/block_encoder.sv */
module block_encoder
(
    input  logic                           i_clock,
    input  logic                           i_reset,
    input  logic                           i_enable,
    input  logic                           i_valid,
    input  logic [pcs_pkg::DATA_W-1:0]     i_data,
    input  logic [pcs_pkg::CTRL_W-1:0]     i_ctrl,
    output logic [pcs_pkg::BLOCK_W-1:0]    o_block,
    output logic                           o_valid
);
    import pcs_pkg::*;

    logic                 is_ctrl;
    logic [BLOCK_W-1:0]   block_next;

    assign is_ctrl = |i_ctrl;

    always_comb
    begin
        if (is_ctrl)
        begin
            // mask takes the place of byte 0
            block_next = {HDR_CTRL, i_data[DATA_W-1:CTRL_W], i_ctrl};
        end
        else
        begin
            block_next = {HDR_DATA, i_data};
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid & i_enable;
        end
    end

    always_ff @(posedge i_clock)
    begin
        o_block <= block_next; // payload, no reset
    end

endmodule

/* logic/gpio_register_file.sv */
module gpio_register_file
(
    input  logic                               i_clock,
    input  logic                               i_reset,
    input  logic [pcs_pkg::GPIO_W-1:0]         i_gpio_in,
    input  logic [pcs_pkg::DATA_W-1:0]         i_ram_data,
    input  logic [pcs_pkg::CTRL_W-1:0]         i_ram_ctrl,
    input  logic [pcs_pkg::RAM_ADDR_W-1:0]     i_ram_wptr,
    output logic [pcs_pkg::GPIO_W-1:0]         o_gpio_out,
    output logic [pcs_pkg::N_STAGES-1:0]       o_stage_enable,
    output logic                               o_read_enable,
    output logic [pcs_pkg::RAM_ADDR_W-1:0]     o_read_address,
    output logic                               o_invalid_opcode
);
    import pcs_pkg::*;

    logic                  strobe;
    logic [OPCODE_W-1:0]   opcode;
    logic [ARG_W-1:0]      arg;
    logic [GPIO_W-1:0]     status_word;

    assign strobe = i_gpio_in[GPIO_W-1]; // command strobe in msb
    assign opcode = i_gpio_in[GPIO_W-2 -: OPCODE_W];
    assign arg    = i_gpio_in[ARG_W-1:0];

    always_comb
    begin
        status_word                   = '0;
        status_word[N_STAGES-1:0]     = o_stage_enable;
        status_word[STATUS_RD_EN_BIT] = o_read_enable;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_gpio_out       <= '0;
            o_stage_enable   <= '0;
            o_read_enable    <= 1'b0;
            o_read_address   <= '0;
            o_invalid_opcode <= 1'b0;
        end
        else if (strobe)
        begin
            case (opcode)
                OP_ENABLE:
                begin
                    o_stage_enable <= arg[N_STAGES-1:0];
                end
                OP_READ_MEM_ENB:
                begin
                    o_read_enable <= arg[0];
                end
                OP_READ_ADDR:
                begin
                    o_read_address <= arg[RAM_ADDR_W-1:0];
                end
                OP_READ_DATA_LOW:
                begin
                    o_gpio_out <= i_ram_data[GPIO_W-1:0];
                end
                OP_READ_DATA_HIGH:
                begin
                    o_gpio_out <= i_ram_data[DATA_W-1:GPIO_W];
                end
                OP_READ_CTRL:
                begin
                    o_gpio_out <= {{(GPIO_W-CTRL_W){1'b0}}, i_ram_ctrl};
                end
                OP_READ_STATUS:
                begin
                    o_gpio_out <= status_word;
                end
                OP_READ_WPTR:
                begin
                    o_gpio_out <= {{(GPIO_W-RAM_ADDR_W){1'b0}}, i_ram_wptr};
                end
                default:
                begin
                    o_invalid_opcode <= 1'b1; // sticky until reset
                end
            endcase
        end
    end

endmodule

/* logic/pcs_pkg.sv */
package pcs_pkg;

    // gpio word layout
    localparam int GPIO_W   = 32;
    localparam int OPCODE_W = 9;
    localparam int ARG_W    = 22;

    // block geometry
    localparam int DATA_W  = 64;
    localparam int CTRL_W  = 8;
    localparam int BLOCK_W = 66;
    localparam int HDR_W   = BLOCK_W - DATA_W;

    localparam logic [HDR_W-1:0] HDR_DATA = 2'b01;
    localparam logic [HDR_W-1:0] HDR_CTRL = 2'b10;

    // capture ram
    localparam int RAM_DEPTH  = 1024;
    localparam int RAM_ADDR_W = 10;

    // stage enable positions
    localparam int ENB_ENCODER     = 0;
    localparam int ENB_SCRAMBLER   = 1;
    localparam int ENB_DESCRAMBLER = 2;
    localparam int ENB_DECODER     = 3;
    localparam int ENB_RAM         = 4;
    localparam int N_STAGES        = 5;

    localparam int STATUS_RD_EN_BIT = 8; // read enable in status word

    // x^58 + x^39 + 1
    localparam int SCR_TAP_A = 39;
    localparam int SCR_TAP_B = 58;

    typedef enum logic [OPCODE_W-1:0] {
        OP_ENABLE         = 9'd0,
        OP_READ_MEM_ENB   = 9'd1,
        OP_READ_ADDR      = 9'd2,
        OP_READ_DATA_LOW  = 9'd3,
        OP_READ_DATA_HIGH = 9'd4,
        OP_READ_CTRL      = 9'd5,
        OP_READ_STATUS    = 9'd6,
        OP_READ_WPTR      = 9'd7
    } opcode_e;

endpackage
